//--- logic/vid_timing_pkg.sv
// XGA raster timing definitions
package vid_timing_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // horizontal geometry, clocks per line

   localparam int H_ACTIVE = 1024;
   localparam int H_FRONT  = 24;
   localparam int H_SYNC   = 136;
   localparam int H_BACK   = 160;
   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

   // hsync low window, start inclusive and end exclusive
   localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
   localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

   ////////////////////////////////////////////////////////////////////////////
   // vertical geometry, lines per frame

   localparam int V_ACTIVE = 768;
   localparam int V_FRONT  = 3;
   localparam int V_SYNC   = 6;
   localparam int V_BACK   = 29;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
   localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

   localparam int HCOUNT_W = 11;
   localparam int VCOUNT_W = 10;

   // pipeline depth from raster position to scan-out pixel
   localparam int SCAN_LAT = 4;
   // and from raster position to the video pins
   localparam int PIX_LAT  = 5;

   // one raster position together with its sync and blank flags
   typedef struct packed {
      logic [HCOUNT_W-1:0] hcount;
      logic [VCOUNT_W-1:0] vcount;
      logic                hsync_n;
      logic                vsync_n;
      logic                blank;
   } raster_pos_t;

   // grey level
   typedef logic [7:0] pixel_t;

   typedef enum logic {SRC_FRAMEBUF, SRC_VBARS} disp_src_e;

   // position (0,0) with syncs idle and the pixel visible
   localparam raster_pos_t POS_RESET = '{hcount: '0, vcount: '0, hsync_n: 1'b1,
                                         vsync_n: 1'b1, blank: 1'b0};

endpackage

//--- logic/vram_pkg.sv
// Video memory definitions
package vram_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // ZBT SRAM geometry

   // 512k words of 36 bits
   localparam int ADDR_W = 19;
   localparam int WORD_W = 36;

   // one pixel per byte lane, four lanes in the low 32 bits
   localparam int BYTES_PER_WORD = 4;

   // pipelined ZBT: data on the pins two clocks after the address
   localparam int MEM_LAT = 2;

   typedef logic [ADDR_W-1:0] vram_addr_t;
   typedef logic [WORD_W-1:0] vram_word_t;

   // one access request, taken in the cycle it is valid
   // data is ignored for reads
   typedef struct packed {
      logic       valid;
      vram_addr_t addr;
      vram_word_t data;
   } vram_req_t;

   ////////////////////////////////////////////////////////////////////////////
   // operation tags and pattern selection

   // what a memory pipeline stage is doing
   typedef enum logic [1:0] {
      OP_IDLE,
      OP_READ,
      OP_WRITE
   } vram_op_e;

   // width of one horizontal bar in pattern writer counts
   typedef enum logic {
      PERIOD_8,
      PERIOD_16
   } bar_period_e;

endpackage

//--- logic/xga_timing.sv
// XGA timing generator
`timescale 1ns/1ps

module xga_timing import vid_timing_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   output raster_pos_t pos
);

   logic                h_wrap;
   logic                v_wrap;
   logic [HCOUNT_W-1:0] h_next;
   logic [VCOUNT_W-1:0] v_next;
   raster_pos_t         pos_next;

   ////////////////////////////////////////////////////////////////////////////
   // next position

   always_comb
   begin
      h_wrap = (pos.hcount == HCOUNT_W'(H_TOTAL - 1));
      v_wrap = (pos.vcount == VCOUNT_W'(V_TOTAL - 1));

      // column runs every clock
      if (h_wrap)
         h_next = '0;
      else
         h_next = pos.hcount + 1'b1;

      // line steps only at end of line
      if (!h_wrap)
         v_next = pos.vcount;
      else if (v_wrap)
         v_next = '0;
      else
         v_next = pos.vcount + 1'b1;

      // flags decoded from the next counts, so they register together
      pos_next.hcount  = h_next;
      pos_next.vcount  = v_next;
      pos_next.hsync_n = !((h_next >= HCOUNT_W'(H_SYNC_START)) &&
                           (h_next <  HCOUNT_W'(H_SYNC_END)));
      pos_next.vsync_n = !((v_next >= VCOUNT_W'(V_SYNC_START)) &&
                           (v_next <  VCOUNT_W'(V_SYNC_END)));
      pos_next.blank   = (h_next >= HCOUNT_W'(H_ACTIVE)) ||
                         (v_next >= VCOUNT_W'(V_ACTIVE));
   end

   ////////////////////////////////////////////////////////////////////////////
   // raster register

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pos <= POS_RESET;
      else
         pos <= pos_next;
   end

   // column must never reach the line length
   a_hcount_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      pos.hcount < HCOUNT_W'(H_TOTAL)
   ) else $error("hcount out of range");

endmodule

//--- logic/zbt_port.sv
// ZBT SRAM port
`timescale 1ns/1ps

module zbt_port import vram_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  vram_req_t  rd_req,
   input  vram_req_t  wr_req,
   output vram_word_t rd_data,
   output logic       rd_valid,
   output vram_addr_t ram_addr,
   output logic       ram_we_n,
   output vram_word_t ram_dq_out,
   output logic       ram_dq_oe,
   input  vram_word_t ram_dq_in
);

   vram_op_e   op_in;
   // stage 0 lines up with the address on the pins
   vram_op_e   op_pipe    [0:MEM_LAT];
   vram_word_t wdata_pipe [0:MEM_LAT];

   ////////////////////////////////////////////////////////////////////////////
   // request select

   // write wins, although both valid together never happens
   always_comb
   begin
      if (wr_req.valid)
         op_in = OP_WRITE;
      else if (rd_req.valid)
         op_in = OP_READ;
      else
         op_in = OP_IDLE;
   end

   ////////////////////////////////////////////////////////////////////////////
   // control pipeline

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ram_we_n <= 1'b1;
         for (int i = 0; i <= MEM_LAT; i++)
            op_pipe[i] <= OP_IDLE;
      end
      else
      begin
         ram_we_n   <= !wr_req.valid;
         op_pipe[0] <= op_in;
         for (int i = 1; i <= MEM_LAT; i++)
            op_pipe[i] <= op_pipe[i-1];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // address and write data

   always_ff @(posedge clk)
   begin
      if (wr_req.valid)
         ram_addr <= wr_req.addr;
      else
         ram_addr <= rd_req.addr;

      // write data trails the address by MEM_LAT
      wdata_pipe[0] <= wr_req.data;
      for (int i = 1; i <= MEM_LAT; i++)
         wdata_pipe[i] <= wdata_pipe[i-1];
   end

   // last stage owns the data bus
   assign ram_dq_out = wdata_pipe[MEM_LAT];
   assign ram_dq_oe  = (op_pipe[MEM_LAT] == OP_WRITE);

   // read data is on the pins in the last stage
   assign rd_data  = ram_dq_in;
   assign rd_valid = (op_pipe[MEM_LAT] == OP_READ);

   // scan-out and pattern writer are scheduled apart by the raster
   a_no_collision: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(rd_req.valid && wr_req.valid)
   ) else $error("read and write requested together");

   // bus driven only for a write address MEM_LAT clocks back
   a_oe_write_only: assert property (
      @(posedge clk) disable iff (!rst_n)
      ram_dq_oe |-> $past(!ram_we_n, MEM_LAT)
   ) else $error("data bus driven outside a write");

endmodule

//--- logic/vram_scanout.sv
// Frame buffer scan-out
`timescale 1ns/1ps

module vram_scanout import vid_timing_pkg::*, vram_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  raster_pos_t pos,
   output vram_req_t   rd_req,
   input  vram_word_t  rd_data,
   input  logic        rd_valid,
   output pixel_t      pix,
   output raster_pos_t pix_pos
);

   raster_pos_t pos_pipe [0:SCAN_LAT-1];
   vram_word_t  word_q;
   logic [1:0]  lane;

   ////////////////////////////////////////////////////////////////////////////
   // read issue

   // one read per four active columns
   // address is 256 words per line plus column / 4
   always_comb
   begin
      rd_req.valid = !pos.blank && (pos.hcount[1:0] == 2'd0);
      rd_req.addr  = vram_addr_t'({pos.vcount, pos.hcount[9:2]});
      rd_req.data  = '0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // position delay and word latch

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < SCAN_LAT; i++)
            pos_pipe[i] <= POS_RESET;
         word_q <= '0;
      end
      else
      begin
         pos_pipe[0] <= pos;
         for (int i = 1; i < SCAN_LAT; i++)
            pos_pipe[i] <= pos_pipe[i-1];
         // word holds for its four pixels until the next read returns
         if (rd_valid)
            word_q <= rd_data;
      end
   end

   assign pix_pos = pos_pipe[SCAN_LAT-1];

   ////////////////////////////////////////////////////////////////////////////
   // byte lane select

   // leftmost pixel sits in the top lane, bits 35:32 unused
   assign lane = 2'(BYTES_PER_WORD - 1) - pix_pos.hcount[1:0];
   assign pix  = word_q[lane*$bits(pixel_t) +: $bits(pixel_t)];

   // returned word must belong to a first column of a group, active video
   a_read_return: assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_valid |-> (pos_pipe[SCAN_LAT-2].hcount[1:0] == 2'd0) &&
                   !pos_pipe[SCAN_LAT-2].blank
   ) else $error("read data returned at wrong raster position");

endmodule

//--- logic/pattern_writer.sv
// Bar pattern writer
`timescale 1ns/1ps

module pattern_writer import vram_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        blank,
   input  bar_period_e period,
   output vram_req_t   wr_req
);

   logic [31:0] cycle_cnt;
   logic [3:0]  bar_nib;

   ////////////////////////////////////////////////////////////////////////////
   // cycle counter

   // free running from reset, doubles as write address
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         cycle_cnt <= '0;
      else
         cycle_cnt <= cycle_cnt + 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // pattern word

   // grey level steps every 8 or 16 addresses
   always_comb
   begin
      if (period == PERIOD_16)
         bar_nib = cycle_cnt[7:4];
      else
         bar_nib = cycle_cnt[6:3];
   end

   // only blanking cycles are free for writes
   always_comb
   begin
      wr_req.valid = blank;
      wr_req.addr  = cycle_cnt[ADDR_W-1:0];
      // same byte in all four lanes, top nibble of the word left zero
      wr_req.data  = vram_word_t'({BYTES_PER_WORD{bar_nib, 4'h0}});
   end

endmodule

//--- logic/video_out_stage.sv
// Video output stage
`timescale 1ns/1ps

module video_out_stage import vid_timing_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  disp_src_e   src,
   input  pixel_t      pix,
   input  raster_pos_t pix_pos,
   output pixel_t      vga_pixel,
   output logic        vga_hsync_n,
   output logic        vga_vsync_n,
   output logic        vga_blank
);

   pixel_t pix_sel;

   ////////////////////////////////////////////////////////////////////////////
   // source select

   always_comb
   begin
      // black outside the active area
      if (pix_pos.blank)
         pix_sel = '0;
      // hardwired bars, eight shades across 64 columns each
      else if (src == SRC_VBARS)
         pix_sel = {pix_pos.hcount[8:6], 5'b0};
      else
         pix_sel = pix;
   end

   ////////////////////////////////////////////////////////////////////////////
   // output registers

   // sync and blank take the same single stage as the pixel
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         vga_pixel   <= '0;
         vga_hsync_n <= 1'b1;
         vga_vsync_n <= 1'b1;
         vga_blank   <= 1'b0;
      end
      else
      begin
         vga_pixel   <= pix_sel;
         vga_hsync_n <= pix_pos.hsync_n;
         vga_vsync_n <= pix_pos.vsync_n;
         vga_blank   <= pix_pos.blank;
      end
   end

endmodule

//--- logic/frame_buffer_top.sv
// Frame buffer display top
`timescale 1ns/1ps

module frame_buffer_top import vid_timing_pkg::*, vram_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  disp_src_e   src,
   input  bar_period_e period,
   output pixel_t      vga_pixel,
   output logic        vga_hsync_n,
   output logic        vga_vsync_n,
   output logic        vga_blank,
   output vram_addr_t  ram_addr,
   output logic        ram_we_n,
   output vram_word_t  ram_dq_out,
   output logic        ram_dq_oe,
   input  vram_word_t  ram_dq_in
);

   raster_pos_t pos;
   raster_pos_t scan_pos;
   pixel_t      scan_pix;
   vram_req_t   rd_req;
   vram_req_t   wr_req;
   vram_word_t  rd_data;
   logic        rd_valid;

   xga_timing u_timing (.clk, .rst_n, .pos);

   // reads in active video, writes in blanking
   zbt_port u_port (
      .clk, .rst_n, .rd_req, .wr_req, .rd_data, .rd_valid,
      .ram_addr, .ram_we_n, .ram_dq_out, .ram_dq_oe, .ram_dq_in
   );

   vram_scanout u_scan (
      .clk, .rst_n, .pos, .rd_req, .rd_data, .rd_valid,
      .pix(scan_pix), .pix_pos(scan_pos)
   );

   pattern_writer u_pattern (.clk, .rst_n, .blank(pos.blank), .period, .wr_req);

   video_out_stage u_out (
      .clk, .rst_n, .src, .pix(scan_pix), .pix_pos(scan_pos),
      .vga_pixel, .vga_hsync_n, .vga_vsync_n, .vga_blank
   );

   // end to end delay of sync and blank through scan-out and output stage
   a_hsync_lat: assert property (
      @(posedge clk) disable iff (!rst_n)
      !pos.hsync_n |-> ##PIX_LAT !vga_hsync_n
   ) else $error("hsync delay mismatch");

   a_blank_lat: assert property (
      @(posedge clk) disable iff (!rst_n)
      pos.blank |-> ##PIX_LAT vga_blank
   ) else $error("blank delay mismatch");

endmodule

//--- tb/zbt_model.sv
// Pipelined ZBT SRAM model
`timescale 1ns/1ps

module zbt_model import vram_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  vram_addr_t ram_addr,
   input  logic       ram_we_n,
   input  vram_word_t ram_dq_out,
   input  logic       ram_dq_oe,
   output vram_word_t ram_dq_in,
   output logic       wr_seen,
   output vram_addr_t wr_seen_addr,
   output vram_word_t wr_seen_data,
   output logic       bus_fault
);

   // one access in flight, chip enable is always on
   typedef struct packed {
      logic       write;
      vram_addr_t addr;
   } slot_t;

   // sparse storage, only written words exist
   vram_word_t mem [vram_addr_t];
   slot_t      stage [0:MEM_LAT-1];

   // unwritten or unknown address reads as zero
   function automatic vram_word_t peek(input vram_addr_t a);
      if ($isunknown(a))
         return '0;
      if (mem.exists(a))
         return mem[a];
      return '0;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // access pipeline

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < MEM_LAT; i++)
            stage[i] <= '0;
         wr_seen   <= 1'b0;
         bus_fault <= 1'b0;
         ram_dq_in <= '0;
      end
      else
      begin
         stage[0] <= '{write: !ram_we_n, addr: ram_addr};
         for (int i = 1; i < MEM_LAT; i++)
            stage[i] <= stage[i-1];
         // last stage owns the data bus this cycle
         wr_seen <= stage[MEM_LAT-1].write;
         if (stage[MEM_LAT-1].write)
         begin
            // write data must come with the bus enabled
            if (!ram_dq_oe)
               bus_fault <= 1'b1;
            mem[stage[MEM_LAT-1].addr] = ram_dq_out;
            wr_seen_addr <= stage[MEM_LAT-1].addr;
            wr_seen_data <= ram_dq_out;
         end
         else if (ram_dq_oe)
            bus_fault <= 1'b1;
         // read data lands on the pins as its slot reaches the last stage
         if (stage[MEM_LAT-2].write)
            ram_dq_in <= '0;
         else
            ram_dq_in <= peek(stage[MEM_LAT-2].addr);
      end
   end

endmodule

//--- tb/tb_frame_buffer.sv
// Frame buffer display testbench
`timescale 1ns/1ps

module tb_frame_buffer import vid_timing_pkg::*, vram_pkg::*;
;

   localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
   localparam int TIMEOUT_CYC = 4 * FRAME_CYC + 1000;
   // request, address register, MEM_LAT, model report register
   localparam int WR_SEEN_LAT = 1 + MEM_LAT + 1;

   logic        clk;
   logic        rst_n;
   disp_src_e   src;
   bar_period_e period;
   pixel_t      vga_pixel;
   logic        vga_hsync_n;
   logic        vga_vsync_n;
   logic        vga_blank;
   vram_addr_t  ram_addr;
   logic        ram_we_n;
   vram_word_t  ram_dq_out;
   logic        ram_dq_oe;
   vram_word_t  ram_dq_in;
   logic        wr_seen;
   vram_addr_t  wr_seen_addr;
   vram_word_t  wr_seen_data;
   logic        sram_fault;
   // raster index of the current cycle, 0 in the first cycle after reset
   int unsigned cyc = 0;
   bar_period_e per_hist [0:7];

   frame_buffer_top dut (.*);

   zbt_model sram (
      .clk, .rst_n, .ram_addr, .ram_we_n, .ram_dq_out, .ram_dq_oe, .ram_dq_in,
      .wr_seen, .wr_seen_addr, .wr_seen_data, .bus_fault(sram_fault)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      if (!rst_n)
         cyc <= 0;
      else
         cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("Something failed");
         $fatal(1, "stopped by cycle limit");
      end
   end

   // period in force during each recent cycle
   always @(negedge clk)
      per_hist[cyc % 8] <= period;

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                        input string what);
      if (actual !== expected)
      begin
         $display("FAIL at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
         $display("Something failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   // blank for a raster index counted from reset
   function automatic logic blank_at(input int unsigned k);
      int unsigned h;
      int unsigned v;
      h = k % H_TOTAL;
      v = (k / H_TOTAL) % V_TOTAL;
      return (h >= H_ACTIVE) || (v >= V_ACTIVE);
   endfunction

   // four equal bytes, grey level in the high nibble
   function automatic vram_word_t bar_word(input int unsigned t, input bar_period_e per);
      logic [7:0] b;
      b = (per == PERIOD_16) ? {t[7:4], 4'h0} : {t[6:3], 4'h0};
      return {4'h0, b, b, b, b};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // tests

   task automatic watch_bus();
      forever
      begin
         @(negedge clk);
         check(sram_fault, 1'b0, "data bus enable against write slot");
         // write on the pins was requested one cycle earlier
         if (!ram_we_n && cyc > 0)
            check(blank_at(cyc - 1), 1'b1, "write on the pins during active video");
      end
   endtask

   task automatic reset_test();
      @(negedge clk);
      check(ram_we_n, 1'b1, "ram_we_n after reset");
      check(ram_dq_oe, 1'b0, "ram_dq_oe after reset");
      check(vga_hsync_n, 1'b1, "hsync after reset");
      check(vga_vsync_n, 1'b1, "vsync after reset");
      check(vga_blank, 1'b0, "blank after reset");
   endtask

   task automatic vbars_test(input int lines);
      int   col;
      int   falls;
      logic known;
      logic blank_q;
      step();
      src     = SRC_VBARS;
      col     = 0;
      falls   = 0;
      known   = 1'b0;
      blank_q = 1'b0;
      while (falls <= lines)
      begin
         @(negedge clk);
         // column zero is where blank falls
         if (blank_q && !vga_blank)
         begin
            known = 1'b1;
            col   = 0;
            falls++;
         end
         else
            col++;
         blank_q = vga_blank;
         if (known && vga_blank)
            check(vga_pixel, 8'h00, "pixel while blank");
         else if (known)
            check(vga_pixel, {col[8:6], 5'b0}, "vertical bar pixel");
      end
   endtask

   task automatic raster_test();
      logic        hs_q;
      logic        vs_q;
      logic        bl_q;
      int unsigned hs_fall;
      int unsigned vs_fall;
      int          hs_falls;
      int          vs_falls;
      int          runs;
      int          run_len;
      hs_q     = 1'b0;
      vs_q     = 1'b0;
      bl_q     = 1'b1;
      hs_falls = 0;
      vs_falls = 0;
      runs     = 0;
      run_len  = 0;
      // two vsync falls frame one complete frame
      while (vs_falls < 2)
      begin
         @(negedge clk);
         if (hs_q && !vga_hsync_n)
         begin
            if (hs_falls > 0)
               check(cyc - hs_fall, H_TOTAL, "hsync period");
            hs_fall = cyc;
            hs_falls++;
         end
         if (!hs_q && vga_hsync_n && hs_falls > 0)
            check(cyc - hs_fall, H_SYNC, "hsync low width");
         if (vs_q && !vga_vsync_n)
         begin
            if (vs_falls > 0)
            begin
               check(cyc - vs_fall, FRAME_CYC, "vsync period");
               check(runs, V_ACTIVE, "active lines per frame");
            end
            vs_fall = cyc;
            runs    = 0;
            vs_falls++;
         end
         if (!vs_q && vga_vsync_n && vs_falls > 0)
            check(cyc - vs_fall, V_SYNC * H_TOTAL, "vsync low width");
         // active runs, counted only inside a whole frame
         if (!vga_blank)
            run_len = bl_q ? 1 : run_len + 1;
         else if (!bl_q && vs_falls > 0)
         begin
            check(run_len, H_ACTIVE, "active run length");
            runs++;
         end
         hs_q = vga_hsync_n;
         vs_q = vga_vsync_n;
         bl_q = vga_blank;
      end
   endtask

   task automatic pattern_test(input bar_period_e per, input int lines);
      int unsigned t;
      step();
      period = per;
      repeat (lines * H_TOTAL)
      begin
         @(negedge clk);
         // raster index of the request behind this model report
         t = cyc - WR_SEEN_LAT;
         check(wr_seen, blank_at(t), "write slot against blank");
         if (wr_seen)
         begin
            check(wr_seen_addr, t[ADDR_W-1:0], "write address");
            check(wr_seen_data, bar_word(t, per_hist[t % 8]), "write data");
         end
      end
   endtask

   task automatic framebuf_test();
      int unsigned first;
      int unsigned p;
      int          h;
      int          v;
      vram_word_t  w;
      logic        sample_line [0:V_ACTIVE-1];
      step();
      src = SRC_FRAMEBUF;
      // next frame start, memory has filled for at least a frame by now
      first = (cyc / FRAME_CYC + 1) * FRAME_CYC;
      for (int i = 0; i < V_ACTIVE; i++)
         sample_line[i] = ($urandom % 4 == 0);
      while (cyc < first + PIX_LAT + V_ACTIVE * H_TOTAL)
      begin
         @(negedge clk);
         if (cyc >= first + PIX_LAT)
         begin
            p = cyc - PIX_LAT - first;
            h = p % H_TOTAL;
            v = p / H_TOTAL;
            if (h < H_ACTIVE && sample_line[v])
            begin
               // one word per four pixels, leftmost pixel in lane 3
               if (h % 4 == 0)
                  w = sram.peek(vram_addr_t'(v * 256 + h / 4));
               check(vga_blank, 1'b0, "blank in active area");
               check(vga_pixel, w[(3 - h % 4) * 8 +: 8], "frame buffer pixel");
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sequence

   initial
   begin
      clk    = 1'b0;
      rst_n  = 1'b0;
      src    = SRC_VBARS;
      period = PERIOD_16;
      void'($urandom(32'h4c3e_e7da));
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      fork
         watch_bus();
      join_none
      reset_test();
      vbars_test(4);
      raster_test();
      pattern_test(PERIOD_8, 2);
      pattern_test(PERIOD_16, 2);
      framebuf_test();
      $display("Everything OK");
      $finish;
   end

endmodule

//--- sim.f
logic/vid_timing_pkg.sv
logic/vram_pkg.sv
logic/xga_timing.sv
logic/zbt_port.sv
logic/vram_scanout.sv
logic/pattern_writer.sv
logic/video_out_stage.sv
logic/frame_buffer_top.sv
tb/zbt_model.sv
tb/tb_frame_buffer.sv
